// ==== bench/frame_butterfly_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "frame_consts.svh"

module frame_butterfly_tb;
  import frame_pkg::*;

  localparam int TOTAL_FRAMES    = 25; // 1 known, 12 back to back, 6 stalled, 6 gapped.
  localparam int WATCHDOG_CYCLES = TOTAL_FRAMES * `N_SAMPLES * 4 + 200;
  localparam sample_t SMAX = {1'b0, {(`SAMPLE_WIDTH-1){1'b1}}};
  localparam sample_t SMIN = {1'b1, {(`SAMPLE_WIDTH-1){1'b0}}};

  logic    clk;
  logic    reset;
  sample_t in_sample;
  logic    in_val;
  logic    in_rdy;
  sample_t out_sample;
  logic    out_val;
  logic    out_rdy;

  integer  seed = 32'h9a31_0860;
  logic    stall_out = 1'b0; // randomise out_rdy.
  logic    gaps_on   = 1'b0; // randomise in_val.

  sample_t in_q [$];
  sample_t exp_q [$];
  frame_t  frame_buf;
  sample_t exp_head = '0;
  logic    exp_avail = 1'b0;
  logic    reset_q = 1'b0;
  int      in_count = 0;
  int      out_count = 0;
  int      errors = 0;
  int      checks = 0;
  int      end_errors = 0;
  int      end_checks = 0;

  frame_butterfly i_dut (
    .clk        (clk),
    .reset      (reset),
    .in_sample  (in_sample),
    .in_val     (in_val),
    .in_rdy     (in_rdy),
    .out_sample (out_sample),
    .out_val    (out_val),
    .out_rdy    (out_rdy)
  );

  initial clk = 1'b0;
  always #10 clk = ~clk;

  // expected output k of one frame.
  function automatic sample_t model_output(input frame_t f, input int k);
    if (k < `HALF_SAMPLES) begin
      return f[k] + f[k + `HALF_SAMPLES];
    end
    return f[k - `HALF_SAMPLES] - f[k];
  endfunction

  // pairs chosen so that sums and differences leave the signed range.
  function automatic sample_t edge_value(input int k);
    case (k % 8)
      0: return SMAX;
      1: return SMIN;
      2: return SMAX;
      3: return SMIN;
      4: return sample_t'(1);
      5: return sample_t'(1);
      6: return sample_t'(-1);
      default: return SMIN;
    endcase
  endfunction

  // transfers are taken from pre-edge values.
  always @(posedge clk) begin
    if (reset_q) checks++; // reset state check.
    reset_q <= reset;
    if (reset) begin
      exp_avail <= 1'b0;
    end else begin
      if (out_val && out_rdy) begin
        if (exp_q.size() > 0) void'(exp_q.pop_front());
        out_count++;
        checks++;
      end
      if (out_val && !out_rdy) checks++;
      if (in_val && in_rdy) begin
        in_q.push_back(in_sample);
        in_count++;
        if (in_q.size() == `N_SAMPLES) begin
          for (int k = 0; k < `N_SAMPLES; k++) frame_buf[k] = in_q.pop_front();
          for (int k = 0; k < `N_SAMPLES; k++) exp_q.push_back(model_output(frame_buf, k));
        end
      end
      exp_avail <= (exp_q.size() > 0);
      if (exp_q.size() > 0) exp_head <= exp_q[0];
    end
  end

  assert property (@(posedge clk) $past(reset) |-> !out_val && in_rdy)
  else begin
    errors++;
    $display("Reset state wrong at %0t: out_val must be low and in_rdy high.", $time);
  end

  assert property (@(posedge clk) disable iff (reset) out_val && out_rdy |-> exp_avail)
  else begin
    errors++;
    $display("Output transfer at %0t with no expected sample left.", $time);
  end

  assert property (@(posedge clk) disable iff (reset)
    out_val && out_rdy && exp_avail |-> out_sample == exp_head)
  else begin
    errors++;
    $display("Mismatch at %0t: expected %0d, got %0d", $time,
             $sampled(exp_head), $sampled(out_sample));
  end

  assert property (@(posedge clk) disable iff (reset)
    out_val && !out_rdy |=> out_val && $stable(out_sample))
  else begin
    errors++;
    $display("Output sample or valid changed while stalled at %0t.", $time);
  end

  // one cycle, inputs change 1 ns after the edge.
  task automatic step();
    @(posedge clk);
    #1;
    if (stall_out) begin
      out_rdy = ($random(seed) & 1) != 0;
    end else begin
      out_rdy = 1'b1;
    end
  endtask

  task automatic send_sample(input sample_t s);
    logic taken;
    taken = 1'b0;
    if (gaps_on) begin
      while (($random(seed) & 1) == 0) begin
        in_val = 1'b0;
        step();
      end
    end
    in_val    = 1'b1;
    in_sample = s;
    while (!taken) begin
      @(negedge clk);
      taken = in_rdy;
      step();
    end
  endtask

  task automatic send_random_frame();
    for (int k = 0; k < `N_SAMPLES; k++) send_sample(sample_t'($random(seed)));
  endtask

  task automatic drain();
    in_val = 1'b0;
    while (out_count != in_count) step();
    repeat (2) step();
  endtask

  initial begin
    reset     = 1'b1;
    in_val    = 1'b0;
    in_sample = '0;
    out_rdy   = 1'b1;
    repeat (4) step();
    reset = 1'b0;
    step();

    for (int k = 0; k < `N_SAMPLES; k++) send_sample(edge_value(k));
    drain();

    repeat (12) send_random_frame(); // in_val stays high across frames.
    drain();

    stall_out = 1'b1;
    repeat (6) send_random_frame();
    drain();
    stall_out = 1'b0;

    gaps_on = 1'b1;
    repeat (6) send_random_frame();
    drain();
    gaps_on = 1'b0;

    end_checks = 2;
    assert (exp_q.size() == 0) else begin
      end_errors++;
      $display("Expected queue still holds %0d samples at end of run.", exp_q.size());
    end
    assert (out_count == in_count) else begin
      end_errors++;
      $display("Output count %0d differs from input count %0d.", out_count, in_count);
    end

    $display("Run finished: %0d errors in %0d checks", errors + end_errors,
             checks + end_checks);
    if (errors + end_errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_CYCLES * 20);
    $display("Timeout after %0d cycles, the pipeline did not drain.", WATCHDOG_CYCLES);
    $display("CHECKS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== frame_butterfly.f ====
+incdir+include
source/frame_pkg.sv
source/frame_deserializer.sv
source/butterfly_stage.sv
source/serializer_control.sv
source/frame_serializer.sv
source/frame_butterfly.sv
bench/frame_butterfly_tb.sv

// ==== include/frame_consts.svh ====
`ifndef FRAME_CONSTS_SVH
`define FRAME_CONSTS_SVH

// bits per sample.
`define SAMPLE_WIDTH 16

// samples per frame, a power of two and at least 2.
`define N_SAMPLES 8

`define HALF_SAMPLES (`N_SAMPLES / 2)

`define INDEX_WIDTH $clog2(`N_SAMPLES)

`endif

// ==== run_sim.sh ====
#!/bin/sh
# compile and run the frame_butterfly testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  -f frame_butterfly.f \
  --top-module frame_butterfly_tb \
  -Mdir obj_dir -o sim_frame_butterfly
if [ $? -ne 0 ]; then
  echo "verilator compile failed"
  exit 1
fi

output=$(./obj_dir/sim_frame_butterfly)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -qx "ALL CHECKS PASSED"; then
  exit 0
fi
echo "simulation did not pass"
exit 1

// ==== source/butterfly_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "frame_consts.svh"

module butterfly_stage (
  input  logic              clk,
  input  logic              reset,

  input  frame_pkg::frame_t fd_frame,
  input  logic              fd_val,
  output logic              fd_rdy,

  output frame_pkg::frame_t bf_frame,
  output logic              bf_val,
  input  logic              bf_rdy
);
  import frame_pkg::*;

  frame_t bf_next;
  logic   fd_fire;
  logic   bf_fire;

  assign bf_fire = bf_val && bf_rdy;
  assign fd_rdy  = !bf_val || bf_fire; // refill in the cycle the frame leaves.
  assign fd_fire = fd_val && fd_rdy;

  // sums go to the lower half and differences to the upper half.
  always_comb begin
    for (int i = 0; i < `HALF_SAMPLES; i++) begin
      bf_next[i]                 = fd_frame[i] + fd_frame[i + `HALF_SAMPLES];
      bf_next[i + `HALF_SAMPLES] = fd_frame[i] - fd_frame[i + `HALF_SAMPLES];
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      bf_val <= 1'b0;
    end else if (fd_fire) begin
      bf_val <= 1'b1;
    end else if (bf_fire) begin
      bf_val <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (fd_fire) begin
      bf_frame <= bf_next; // results wrap at the sample width.
    end
  end

endmodule

`default_nettype wire

// ==== source/frame_butterfly.sv ====
`timescale 1ns/1ps
`default_nettype none

module frame_butterfly (
  input  logic               clk,
  input  logic               reset,

  input  frame_pkg::sample_t in_sample,
  input  logic               in_val,
  output logic               in_rdy,

  output frame_pkg::sample_t out_sample,
  output logic               out_val,
  input  logic               out_rdy
);
  import frame_pkg::*;

  frame_t fd_frame; // gathered input frame.
  logic   fd_val;
  logic   fd_rdy;

  frame_t bf_frame; // sum and difference frame.
  logic   bf_val;
  logic   bf_rdy;

  frame_deserializer i_deser (
    .clk       (clk),
    .reset     (reset),
    .in_sample (in_sample),
    .in_val    (in_val),
    .in_rdy    (in_rdy),
    .fd_frame  (fd_frame),
    .fd_val    (fd_val),
    .fd_rdy    (fd_rdy)
  );

  butterfly_stage i_bfly (
    .clk      (clk),
    .reset    (reset),
    .fd_frame (fd_frame),
    .fd_val   (fd_val),
    .fd_rdy   (fd_rdy),
    .bf_frame (bf_frame),
    .bf_val   (bf_val),
    .bf_rdy   (bf_rdy)
  );

  frame_serializer i_ser (
    .clk        (clk),
    .reset      (reset),
    .bf_frame   (bf_frame),
    .bf_val     (bf_val),
    .bf_rdy     (bf_rdy),
    .out_sample (out_sample),
    .out_val    (out_val),
    .out_rdy    (out_rdy)
  );

endmodule

`default_nettype wire

// ==== source/frame_deserializer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "frame_consts.svh"

module frame_deserializer (
  input  logic               clk,
  input  logic               reset,

  input  frame_pkg::sample_t in_sample,
  input  logic               in_val,
  output logic               in_rdy,

  output frame_pkg::frame_t  fd_frame,
  output logic               fd_val,
  input  logic               fd_rdy
);
  import frame_pkg::*;

  index_t wr_idx;
  logic   in_fire;
  logic   fd_fire;
  logic   last_slot;

  assign in_rdy    = !fd_val; // no input while a full frame waits.
  assign in_fire   = in_val && in_rdy;
  assign fd_fire   = fd_val && fd_rdy;
  assign last_slot = (wr_idx == index_t'(`N_SAMPLES - 1));

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_idx <= '0;
    end else if (in_fire) begin
      wr_idx <= wr_idx + index_t'(1); // wraps to 0 after the last slot.
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      fd_val <= 1'b0;
    end else if (in_fire && last_slot) begin
      fd_val <= 1'b1;
    end else if (fd_fire) begin
      fd_val <= 1'b0;
    end
  end

  // sample storage, only written while the frame is still open.
  always_ff @(posedge clk) begin
    if (in_fire) begin
      fd_frame[wr_idx] <= in_sample;
    end
  end

endmodule

`default_nettype wire

// ==== source/frame_pkg.sv ====
`default_nettype none

`include "frame_consts.svh"

package frame_pkg;

  // one signed sample as it travels on the streams.
  typedef logic signed [`SAMPLE_WIDTH-1:0] sample_t;

  // a whole frame with index 0 first in stream order.
  typedef sample_t frame_t [`N_SAMPLES];

  // position of a sample inside a frame.
  typedef logic [`INDEX_WIDTH-1:0] index_t;

endpackage

`default_nettype wire

// ==== source/frame_serializer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "frame_consts.svh"

module frame_serializer (
  input  logic               clk,
  input  logic               reset,

  input  frame_pkg::frame_t  bf_frame,
  input  logic               bf_val,
  output logic               bf_rdy,

  output frame_pkg::sample_t out_sample,
  output logic               out_val,
  input  logic               out_rdy
);
  import frame_pkg::*;

  frame_t bank;
  index_t mux_sel;
  logic   reg_en;

  for (genvar i = 0; i < `N_SAMPLES; i++) begin : g_bank
    always_ff @(posedge clk) begin
      if (reset) begin
        bank[i] <= '0;
      end else if (reg_en) begin
        bank[i] <= bf_frame[i];
      end
    end
  end

  assign out_sample = bank[mux_sel]; // selected entry of the held frame.

  serializer_control i_ctrl (
    .clk      (clk),
    .reset    (reset),
    .recv_val (bf_val),
    .recv_rdy (bf_rdy),
    .send_val (out_val),
    .send_rdy (out_rdy),
    .mux_sel  (mux_sel),
    .reg_en   (reg_en)
  );

endmodule

`default_nettype wire

// ==== source/serializer_control.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "frame_consts.svh"

module serializer_control (
  input  logic              clk,
  input  logic              reset,

  input  logic              recv_val,
  output logic              recv_rdy,

  output logic              send_val,
  input  logic              send_rdy,

  output frame_pkg::index_t mux_sel,
  output logic              reg_en
);
  import frame_pkg::*;

  typedef enum logic {
    ST_LOAD,
    ST_OUTPUT
  } state_t;

  state_t state;
  state_t state_next;
  index_t mux_sel_next;
  logic   send_fire;
  logic   last_index;

  assign send_fire  = send_val && send_rdy;
  assign last_index = (mux_sel == index_t'(`N_SAMPLES - 1));

  always_comb begin
    state_next   = state;
    mux_sel_next = mux_sel;
    case (state)
      ST_LOAD: begin
        mux_sel_next = '0;
        if (recv_val) begin
          state_next = ST_OUTPUT; // bank captures this frame on the same edge.
        end
      end
      ST_OUTPUT: begin
        if (send_fire) begin
          if (last_index) begin
            state_next   = ST_LOAD;
            mux_sel_next = '0;
          end else begin
            mux_sel_next = mux_sel + index_t'(1);
          end
        end
      end
      default: begin
        state_next   = ST_LOAD;
        mux_sel_next = '0;
      end
    endcase
  end

  // load keeps the bank tracking its input until a frame is taken.
  always_comb begin
    reg_en   = (state == ST_LOAD);
    recv_rdy = (state == ST_LOAD);
    send_val = (state == ST_OUTPUT);
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state   <= ST_LOAD;
      mux_sel <= '0;
    end else begin
      state   <= state_next;
      mux_sel <= mux_sel_next;
    end
  end

endmodule

`default_nettype wire
